// ==== tb.f ====
+incdir+hw
hw/heapPkg.sv
hw/requestQueue.sv
hw/arrayDirectory.sv
hw/elementStore.sv
hw/elementAlu.sv
hw/heapController.sv
hw/heapTop.sv
sim/heapTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the heap testbench with Verilator, run it and look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f tb.f --top-module heapTb -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/VheapTb)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// ==== sim/heapTb.sv ====
//------------------------------
// Testbench for the array heap. Sends requests under credit flow
// control, predicts every response with a behavioral model and
// checks the DUT responses with assertions at the falling edge.
//------------------------------
`timescale 1ns/1ps
`include "heap_config.svh"

module heapTb import heapPkg::*; ();

  localparam int timeoutCycles = 200;                // Limit for every wait loop
  localparam int depth         = `HEAP_QUEUE_DEPTH;  // Host credits after reset

  logic       clock = 1'b0;
  logic       resetN;
  logic       requestValid;
  heapOp_t    requestOp;
  arrayNum_t  requestArray;
  elemIndex_t requestIndex;
  heapData_t  requestData;
  logic       creditReturn;
  logic       responseValid;
  heapData_t  responseData;
  heapError_t responseError;

  heapOp_t    expOp   [$];                           // Expected responses, request order
  heapData_t  expData [$];
  heapError_t expErr  [$];

  bit         modelAlive [`HEAP_ARRAYS];             // Reference model state
  int         modelSize  [`HEAP_ARRAYS];
  heapData_t  modelMem   [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  arrayNum_t  modelFree  [$];                        // Freed arrays, newest at back
  int         modelIssued;

  int sentCount = 0;                                 // Written by stimulus only
  int creditCount = 0;                               // Written by monitor only
  int respCount = 0;
  int mismatches = 0;
  int failures = 0;
  int testsPassed = 0;
  int testsFailed = 0;
  int errorsAtStart = 0;
  bit hung = 1'b0;                                   // A wait loop timed out
  bit burst = 1'b0;                                  // No idle gaps between requests

  always #20 clock = ~clock;                         // 40 ns period

  heapTop i_dut (
    .clock, .resetN, .requestValid, .requestOp, .requestArray, .requestIndex,
    .requestData, .creditReturn, .responseValid, .responseData, .responseError
  );

  //------------------------------
  // Monitor, samples at negedge
  //------------------------------
  always @(negedge clock) begin
    heapData_t  wantData;
    heapError_t wantErr;
    if (!resetN) begin
      assert (!creditReturn && !responseValid)
        else begin
          $display("%0t: creditReturn or responseValid is high during reset", $time);
          mismatches++;
        end
    end else begin
      if (creditReturn) creditCount++;               // One credit back per pulse
      assert (sentCount - creditCount >= 0 && sentCount - creditCount <= depth)
        else begin
          $display("%0t: host credit count left the range 0 to %0d", $time, depth);
          mismatches++;
        end
      if (responseValid) begin
        assert (respCount < expData.size())
          else begin
            $display("%0t: response arrived with no request pending", $time);
            mismatches++;
          end
        if (respCount < expData.size()) begin
          wantData = expData[respCount];
          wantErr  = expErr[respCount];
          assert (responseData === wantData)
            else begin
              $display("MISMATCH time=%0t signal=responseData op=%s expected=%h actual=%h",
                       $time, expOp[respCount].name(), wantData, responseData);
              mismatches++;
            end
          assert (responseError === wantErr)
            else begin
              $display("MISMATCH time=%0t signal=responseError op=%s expected=%s actual=%s",
                       $time, expOp[respCount].name(), wantErr.name(), responseError.name());
              mismatches++;
            end
          respCount++;
        end
      end
    end
  end

  //------------------------------
  // Reference model
  //------------------------------
  task automatic predict(input heapOp_t op, input arrayNum_t arr,
                         input elemIndex_t idx, input heapData_t data);
    heapError_t err;
    heapData_t  value;
    heapData_t  old;
    heapData_t  newVal;
    arrayNum_t  pick;
    err    = errNone;
    value  = '0;
    old    = modelMem[arr][idx];
    newVal = '0;
    pick   = '0;
    if (op == opAlloc) begin
      if (modelFree.size() != 0) begin
        pick = modelFree.pop_back();                 // Newest freed first
      end else if (modelIssued < `HEAP_ARRAYS) begin
        pick = arrayNum_t'(modelIssued);
        modelIssued++;
      end else begin
        err = errOutOfMemory;
      end
      if (err == errNone) begin
        modelAlive[pick] = 1'b1;
        modelSize[pick]  = 0;
        value            = heapData_t'(pick);
      end
    end else if (int'(arr) >= modelIssued) begin
      err = errUnallocated;
    end else if (!modelAlive[arr]) begin
      err = errFreed;
    end else begin
      case (op)
        opWrite: begin
          modelMem[arr][idx] = data;
          value = data;
          if (int'(idx) >= modelSize[arr]) modelSize[arr] = int'(idx) + 1;  // Grows
        end
        opRead: begin
          if (int'(idx) >= modelSize[arr]) err = errOutOfBounds;
          else value = old;
        end
        opSize: value = heapData_t'(modelSize[arr]);
        opPush: begin
          if (modelSize[arr] == `HEAP_ARRAY_LENGTH) begin
            err = errFull;
          end else begin
            modelMem[arr][elemIndex_t'(modelSize[arr])] = data;
            value = data;
            modelSize[arr]++;
          end
        end
        opPop: begin
          if (modelSize[arr] == 0) begin
            err = errEmpty;
          end else begin
            modelSize[arr]--;
            value = modelMem[arr][elemIndex_t'(modelSize[arr])];   // Old top
          end
        end
        opFree: begin
          modelAlive[arr] = 1'b0;
          modelFree.push_back(arr);
        end
        default: begin                               // Arithmetic and bitwise
          if (int'(idx) >= modelSize[arr]) begin
            err = errOutOfBounds;
          end else begin
            case (op)
              opAdd, opAddAfter: newVal = old + data;   // Wraps at 16 bits
              opSub, opSubAfter: newVal = old - data;
              opOr:              newVal = old | data;
              opXor:             newVal = old ^ data;
              opAnd:             newVal = old & data;
              default:           newVal = ~old;
            endcase
            modelMem[arr][idx] = newVal;
            value = (op == opAddAfter || op == opSubAfter) ? old : newVal;
          end
        end
      endcase
    end
    expOp.push_back(op);
    expData.push_back(value);
    expErr.push_back(err);
  endtask

  //------------------------------
  // Stimulus helpers
  //------------------------------
  task automatic applyReset();
    resetN = 1'b0;
    repeat (8) @(posedge clock);
    #2;
    resetN = 1'b1;
    modelFree.delete();
    modelIssued = 0;
    for (int i = 0; i < `HEAP_ARRAYS; i++) begin
      modelAlive[i] = 1'b0;
      modelSize[i]  = 0;
    end
  endtask

  // Requests cut off by the reset never answer
  task automatic resetInFlight();
    applyReset();
    while (expData.size() > respCount) begin
      void'(expOp.pop_back());
      void'(expData.pop_back());
      void'(expErr.pop_back());
    end
    sentCount = creditCount;                         // Full credit again
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic sendRequest(input heapOp_t op, input arrayNum_t arr,
                             input elemIndex_t idx, input heapData_t data);
    int cycles;
    int gap;
    cycles = 0;
    if (hung) return;
    while (sentCount - creditCount >= depth && cycles < timeoutCycles) begin
      @(posedge clock);
      #2;
      cycles++;
    end
    assert (sentCount - creditCount < depth)
      else begin
        $display("%0t: no credit came back within %0d cycles", $time, timeoutCycles);
        failures++;
        hung = 1'b1;
      end
    if (hung) return;
    requestValid = 1'b1;                             // Spends one credit
    requestOp    = op;
    requestArray = arr;
    requestIndex = idx;
    requestData  = data;
    sentCount++;
    predict(op, arr, idx, data);
    @(posedge clock);
    #2;
    requestValid = 1'b0;
    gap = burst ? 0 : int'($urandom_range(0, 3));
    repeat (gap) begin
      @(posedge clock);
      #2;
    end
  endtask

  task automatic drainResponses();
    int cycles;
    cycles = 0;
    if (hung) return;
    while (respCount < expData.size() && cycles < timeoutCycles) begin
      @(posedge clock);
      #2;
      cycles++;
    end
    assert (respCount == expData.size())
      else begin
        $display("%0t: %0d responses still missing after %0d cycles",
                 $time, expData.size() - respCount, timeoutCycles);
        failures++;
        hung = 1'b1;
      end
  endtask

  task automatic beginTest();
    applyReset();
    errorsAtStart = mismatches + failures;
  endtask

  task automatic endTest(input string name);
    drainResponses();
    if (mismatches + failures == errorsAtStart) begin
      testsPassed++;
      $display("test %s: passed", name);
    end else begin
      testsFailed++;
      $display("test %s: failed", name);
    end
  endtask

  function automatic heapData_t randomData();
    return heapData_t'($urandom);
  endfunction

  //------------------------------
  // Tests
  //------------------------------
  task automatic allocOrderTest();
    beginTest();
    repeat (3) sendRequest(opAlloc, '0, '0, '0);    // Fresh arrays 0, 1, 2
    sendRequest(opFree, 3'd1, '0, '0);
    sendRequest(opFree, 3'd2, '0, '0);
    sendRequest(opAlloc, '0, '0, '0);               // Reuses 2, then 1
    sendRequest(opAlloc, '0, '0, '0);
    repeat (5) sendRequest(opAlloc, '0, '0, '0);    // Up to eight live arrays
    sendRequest(opAlloc, '0, '0, '0);               // Out of memory
    endTest("allocation order");
  endtask

  task automatic writeReadTest();
    beginTest();
    sendRequest(opAlloc, '0, '0, '0);
    sendRequest(opWrite, 3'd0, 2'd2, randomData());
    sendRequest(opSize, 3'd0, '0, '0);              // Size now 3
    sendRequest(opRead, 3'd0, 2'd2, '0);
    sendRequest(opRead, 3'd0, 2'd3, '0);            // Beyond size
    endTest("write, read and size");
  endtask

  task automatic pushPopTest();
    beginTest();
    sendRequest(opAlloc, '0, '0, '0);
    repeat (5) sendRequest(opPush, 3'd0, '0, randomData());   // Last one is full
    repeat (5) sendRequest(opPop, 3'd0, '0, '0);              // Last one is empty
    endTest("push and pop");
  endtask

  task automatic arithmeticTest();
    beginTest();
    sendRequest(opAlloc, '0, '0, '0);
    sendRequest(opWrite, 3'd0, 2'd0, 16'hfff0);
    sendRequest(opAdd, 3'd0, 2'd0, 16'h0020);       // Wraps past 16 bits
    sendRequest(opAddAfter, 3'd0, 2'd0, randomData());
    sendRequest(opSub, 3'd0, 2'd0, randomData());
    sendRequest(opSubAfter, 3'd0, 2'd0, 16'h8001);
    sendRequest(opOr, 3'd0, 2'd0, randomData());
    sendRequest(opXor, 3'd0, 2'd0, randomData());
    sendRequest(opAnd, 3'd0, 2'd0, randomData());
    sendRequest(opNot, 3'd0, 2'd0, randomData());
    sendRequest(opRead, 3'd0, 2'd0, '0);
    sendRequest(opAdd, 3'd0, 2'd3, 16'h0001);       // Index beyond size
    endTest("arithmetic");
  endtask

  task automatic accessErrorTest();
    beginTest();
    sendRequest(opAlloc, '0, '0, '0);
    sendRequest(opAlloc, '0, '0, '0);
    sendRequest(opWrite, 3'd0, 2'd0, randomData());
    sendRequest(opWrite, 3'd1, 2'd0, randomData());
    sendRequest(opFree, 3'd1, '0, '0);
    sendRequest(opWrite, 3'd7, 2'd0, randomData()); // Never issued
    sendRequest(opRead, 3'd7, 2'd0, '0);
    sendRequest(opAdd, 3'd1, 2'd0, randomData());   // Freed array
    sendRequest(opWrite, 3'd1, 2'd0, randomData());
    sendRequest(opFree, 3'd1, '0, '0);
    sendRequest(opRead, 3'd0, 2'd0, '0);            // Untouched value
    sendRequest(opAlloc, '0, '0, '0);               // Array 1 comes back
    sendRequest(opWrite, 3'd1, 2'd1, randomData()); // Size 2, index 0 kept
    sendRequest(opRead, 3'd1, 2'd0, '0);            // Value from before the free
    endTest("access errors");
  endtask

  task automatic flowControlTest();
    int sent0;
    int credit0;
    int resp0;
    beginTest();
    sendRequest(opAlloc, '0, '0, '0);
    for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
      sendRequest(opWrite, 3'd0, elemIndex_t'(i), randomData());
    end
    drainResponses();
    sent0   = sentCount;
    credit0 = creditCount;
    resp0   = respCount;
    burst   = 1'b1;                                  // Full credit rate
    repeat (16) begin
      case ($urandom_range(0, 2))
        0:       sendRequest(opRead, 3'd0, elemIndex_t'($urandom), '0);
        1:       sendRequest(opAdd, 3'd0, elemIndex_t'($urandom), randomData());
        default: sendRequest(opSize, 3'd0, '0, '0);
      endcase
    end
    burst = 1'b0;
    drainResponses();
    assert (creditCount - credit0 == sentCount - sent0 && respCount - resp0 == sentCount - sent0)
      else begin
        $display("%0t: burst of %0d requests gave %0d credits and %0d responses",
                 $time, sentCount - sent0, creditCount - credit0, respCount - resp0);
        failures++;
      end
    burst = 1'b1;
    repeat (depth) sendRequest(opSize, 3'd0, '0, '0);  // Busy when reset hits
    burst = 1'b0;
    resetInFlight();
    endTest("flow control");
  endtask

  //------------------------------
  // Main sequence
  //------------------------------
  initial begin
    resetN       = 1'b0;
    requestValid = 1'b0;
    requestOp    = opWrite;
    requestArray = '0;
    requestIndex = '0;
    requestData  = '0;
    void'($urandom(32'he311));                       // One seed for the run
    allocOrderTest();
    if (!hung) writeReadTest();
    if (!hung) pushPopTest();
    if (!hung) arithmeticTest();
    if (!hung) accessErrorTest();
    if (!hung) flowControlTest();
    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             testsPassed, testsFailed, mismatches + failures);
    if (testsFailed == 0 && mismatches + failures == 0 && !hung) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/heapTop.sv ====
//------------------------------
// Top level of the array heap. Requests enter under credit flow
// control and each one gets a single response, in order.
//------------------------------
`timescale 1ns/1ps

module heapTop import heapPkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  logic       requestValid,                   // Spends one host credit
  input  heapOp_t    requestOp,
  input  arrayNum_t  requestArray,
  input  elemIndex_t requestIndex,
  input  heapData_t  requestData,
  output logic       creditReturn,                   // One credit back per pulse
  output logic       responseValid,
  output heapData_t  responseData,
  output heapError_t responseError
);

  logic       queueValid, queuePop;
  heapOp_t    headOp;
  arrayNum_t  headArray, lookupArray, allocArray, readArray, writeArray;
  elemIndex_t headIndex, readIndex, writeIndex;
  heapData_t  headData, readData, writeData, aluOperand, aluInput, aluResult;
  logic       isAllocated, wasIssued, allocFailed;
  logic       allocStrobe, freeStrobe, sizeWrite, readEnable, writeEnable;
  arraySize_t arraySize, newSize;
  heapOp_t    aluOp;

  assign creditReturn = queuePop;                    // Popping frees a queue slot

  requestQueue i_queue (
    .clock, .resetN,
    .pushValid(requestValid), .pushOp(requestOp), .pushArray(requestArray),
    .pushIndex(requestIndex), .pushData(requestData),
    .queuePop, .queueValid, .headOp, .headArray, .headIndex, .headData
  );

  heapController i_ctrl (
    .clock, .resetN, .queueValid, .headOp, .headArray, .headIndex, .headData,
    .isAllocated, .wasIssued, .arraySize, .allocArray, .allocFailed, .readData, .aluResult,
    .queuePop, .lookupArray, .allocStrobe, .freeStrobe, .sizeWrite, .newSize,
    .readEnable, .readArray, .readIndex, .writeEnable, .writeArray, .writeIndex, .writeData,
    .aluOp, .aluOperand, .aluInput, .responseValid, .responseData, .responseError
  );

  arrayDirectory i_dir (
    .clock, .resetN, .lookupArray, .allocStrobe, .freeStrobe, .sizeWrite, .newSize,
    .isAllocated, .wasIssued, .arraySize, .allocArray, .allocFailed
  );

  elementStore i_store (
    .clock, .readEnable, .readArray, .readIndex,
    .writeEnable, .writeArray, .writeIndex, .writeData, .readData
  );

  elementAlu i_alu (
    .aluOp, .aluOperand, .aluInput, .aluResult
  );

endmodule

// ==== hw/heapController.sv ====
//------------------------------
// Request sequencer. Takes one request at a time from the queue,
// checks it, reads, updates the store and directory, then responds.
// Every request takes stIdle, stAccess, stUpdate, stRespond.
//------------------------------
`timescale 1ns/1ps
`include "heap_config.svh"

module heapController import heapPkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  logic       queueValid,
  input  heapOp_t    headOp,
  input  arrayNum_t  headArray,
  input  elemIndex_t headIndex,
  input  heapData_t  headData,
  input  logic       isAllocated,
  input  logic       wasIssued,
  input  arraySize_t arraySize,
  input  arrayNum_t  allocArray,
  input  logic       allocFailed,
  input  heapData_t  readData,
  input  heapData_t  aluResult,
  output logic       queuePop,                       // Also the credit pulse
  output arrayNum_t  lookupArray,
  output logic       allocStrobe,
  output logic       freeStrobe,
  output logic       sizeWrite,
  output arraySize_t newSize,
  output logic       readEnable,
  output arrayNum_t  readArray,
  output elemIndex_t readIndex,
  output logic       writeEnable,
  output arrayNum_t  writeArray,
  output elemIndex_t writeIndex,
  output heapData_t  writeData,
  output heapOp_t    aluOp,
  output heapData_t  aluOperand,
  output heapData_t  aluInput,
  output logic       responseValid,
  output heapData_t  responseData,
  output heapError_t responseError
);

  ctrlState_t state;
  heapOp_t    reqOp;                                 // Request being executed
  arrayNum_t  reqArray;
  elemIndex_t reqIndex;
  heapData_t  reqData;
  heapError_t errReg, checkError;
  heapData_t  respReg, respNext;
  logic       isArith, isOk, inUpdate;

  assign isArith  = reqOp inside {opAdd, opAddAfter, opSub, opSubAfter,
                                  opOr, opXor, opAnd, opNot};
  assign isOk     = (errReg == errNone);             // Check passed in stAccess
  assign inUpdate = (state == stUpdate);

  //------------------------------
  // Access checks, first failure wins
  //------------------------------
  always_comb begin
    checkError = errNone;
    if (reqOp != opAlloc) begin
      if (!wasIssued)       checkError = errUnallocated;
      else if (!isAllocated) checkError = errFreed;
      else if ((reqOp == opRead || isArith) && arraySize_t'(reqIndex) >= arraySize)
        checkError = errOutOfBounds;
      else if (reqOp == opPush && arraySize >= arraySize_t'(`HEAP_ARRAY_LENGTH))
        checkError = errFull;
      else if (reqOp == opPop && arraySize == '0)
        checkError = errEmpty;
    end
  end

  //------------------------------
  // Directory, store and ALU drive
  //------------------------------
  assign queuePop    = (state == stIdle) && queueValid;
  assign lookupArray = reqArray;
  assign readArray   = reqArray;
  assign writeArray  = reqArray;
  assign readIndex   = (reqOp == opPop)  ? elemIndex_t'(arraySize - 1'b1) : reqIndex; // Top
  assign writeIndex  = (reqOp == opPush) ? elemIndex_t'(arraySize) : reqIndex;        // Next slot
  assign readEnable  = (state == stAccess) && (checkError == errNone) &&
                       (reqOp == opRead || reqOp == opPop || isArith);
  assign writeEnable = inUpdate && isOk && (reqOp == opWrite || reqOp == opPush || isArith);
  assign writeData   = aluResult;
  assign aluOp       = reqOp;
  assign aluOperand  = reqData;
  assign aluInput    = readData;                     // Valid in stUpdate
  assign allocStrobe = inUpdate && (reqOp == opAlloc);
  assign freeStrobe  = inUpdate && isOk && (reqOp == opFree);

  always_comb begin
    sizeWrite = 1'b0;
    newSize   = arraySize;
    if (inUpdate && isOk) begin
      case (reqOp)
        opWrite: if (arraySize_t'(reqIndex) >= arraySize) begin
          sizeWrite = 1'b1;                          // Grow to cover the index
          newSize   = arraySize_t'(reqIndex) + 1'b1;
        end
        opPush: begin
          sizeWrite = 1'b1;
          newSize   = arraySize + 1'b1;
        end
        opPop: begin
          sizeWrite = 1'b1;
          newSize   = arraySize - 1'b1;
        end
        default: sizeWrite = 1'b0;
      endcase
    end
  end

  // Response value, zero on any failure
  always_comb begin
    respNext = '0;
    if (isOk) begin
      case (reqOp)
        opWrite, opPush, opAdd, opSub,
        opOr, opXor, opAnd, opNot:          respNext = aluResult;   // Now stored
        opAddAfter, opSubAfter,
        opRead, opPop:                      respNext = readData;    // Before update
        opSize:                             respNext = heapData_t'(arraySize);
        opAlloc: if (!allocFailed)          respNext = heapData_t'(allocArray);
        default:                            respNext = '0;
      endcase
    end
  end

  //------------------------------
  // FSM and request capture
  //------------------------------
  always_ff @(posedge clock) begin
    if (queuePop) begin
      reqOp    <= headOp;                            // Held from stAccess on
      reqArray <= headArray;
      reqIndex <= headIndex;
      reqData  <= headData;
    end
    if (inUpdate) respReg <= respNext;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state  <= stIdle;
      errReg <= errNone;
    end else begin
      case (state)
        stIdle:   if (queueValid) state <= stAccess;
        stAccess: begin
          errReg <= checkError;
          state  <= stUpdate;
        end
        stUpdate: begin
          if (allocStrobe && allocFailed) errReg <= errOutOfMemory;
          state <= stRespond;
        end
        default:  state <= stIdle;                   // stRespond, one cycle
      endcase
    end
  end

  assign responseValid = (state == stRespond);
  assign responseData  = respReg;
  assign responseError = errReg;

endmodule

// ==== hw/elementAlu.sv ====
//------------------------------
// Element arithmetic for the update opcodes. Purely
// combinational; write and push take the operand unchanged.
//------------------------------
`timescale 1ns/1ps

module elementAlu import heapPkg::*; (
  input  heapOp_t   aluOp,
  input  heapData_t aluOperand,                      // Request data
  input  heapData_t aluInput,                        // Stored element
  output heapData_t aluResult                        // Value to store
);

  always_comb begin
    case (aluOp)
      opAdd, opAddAfter: aluResult = aluInput + aluOperand;  // Wraps at data width
      opSub, opSubAfter: aluResult = aluInput - aluOperand;
      opOr:              aluResult = aluInput | aluOperand;
      opXor:             aluResult = aluInput ^ aluOperand;
      opAnd:             aluResult = aluInput & aluOperand;
      opNot:             aluResult = ~aluInput;              // Operand ignored
      default:           aluResult = aluOperand;             // Write and push data
    endcase
  end

endmodule

// ==== hw/elementStore.sv ====
//------------------------------
// Element RAM for all arrays, one registered read port and
// one write port. Addressed by array number then index.
//------------------------------
`timescale 1ns/1ps
`include "heap_config.svh"

module elementStore import heapPkg::*; (
  input  logic       clock,
  input  logic       readEnable,                     // Data appears next cycle
  input  arrayNum_t  readArray,
  input  elemIndex_t readIndex,
  input  logic       writeEnable,
  input  arrayNum_t  writeArray,
  input  elemIndex_t writeIndex,
  input  heapData_t  writeData,
  output heapData_t  readData
);

  localparam int words = `HEAP_ARRAYS * `HEAP_ARRAY_LENGTH;

  heapData_t mem [words];                            // Arrays in fixed blocks

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      mem[{writeArray, writeIndex}] <= writeData;
    end
    if (readEnable) begin
      readData <= mem[{readArray, readIndex}];       // Registered read
    end
  end

endmodule

// ==== hw/arrayDirectory.sv ====
//------------------------------
// Array bookkeeping: allocation flags, sizes, the LIFO of freed
// arrays and the count of arrays issued so far. Lookups answer
// combinationally; alloc, free and size writes take one cycle.
//------------------------------
`timescale 1ns/1ps
`include "heap_config.svh"

module arrayDirectory import heapPkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  arrayNum_t  lookupArray,                    // Array under access
  input  logic       allocStrobe,                    // Allocate one array
  input  logic       freeStrobe,                     // Free lookupArray
  input  logic       sizeWrite,                      // Update size of lookupArray
  input  arraySize_t newSize,
  output logic       isAllocated,
  output logic       wasIssued,                      // Issued at least once
  output arraySize_t arraySize,
  output arrayNum_t  allocArray,                     // Array handed out on alloc
  output logic       allocFailed                     // Nothing left to hand out
);

  typedef logic [`HEAP_ARRAY_BITS:0] arrayCount_t;   // Holds 0 to all arrays

  logic [`HEAP_ARRAYS-1:0] allocated;                // One flag per array
  arraySize_t              sizes     [`HEAP_ARRAYS];
  arrayNum_t               freeStack [`HEAP_ARRAYS]; // Freed arrays, newest on top
  arrayCount_t             freeTop;                  // Entries on the stack
  arrayCount_t             issuedCount;              // Arrays ever issued

  //------------------------------
  // Lookup and alloc choice
  //------------------------------
  assign isAllocated = allocated[lookupArray];
  assign arraySize   = sizes[lookupArray];
  assign wasIssued   = (arrayCount_t'(lookupArray) < issuedCount);

  always_comb begin
    allocFailed = 1'b0;
    allocArray  = arrayNum_t'(issuedCount);          // Fresh array by default
    if (freeTop != '0) begin
      allocArray = freeStack[arrayNum_t'(freeTop - 1'b1)]; // Reuse newest freed
    end else if (issuedCount == arrayCount_t'(`HEAP_ARRAYS)) begin
      allocFailed = 1'b1;                            // All issued, none free
    end
  end

  //------------------------------
  // State updates
  //------------------------------
  always_ff @(posedge clock) begin
    if (freeStrobe) freeStack[arrayNum_t'(freeTop)] <= lookupArray;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated   <= '0;
      freeTop     <= '0;
      issuedCount <= '0;
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      if (allocStrobe && !allocFailed) begin
        allocated[allocArray] <= 1'b1;
        sizes[allocArray]     <= '0;                 // New array starts empty
        if (freeTop != '0) freeTop <= freeTop - 1'b1;
        else               issuedCount <= issuedCount + 1'b1;
      end
      if (freeStrobe) begin
        allocated[lookupArray] <= 1'b0;
        freeTop                <= freeTop + 1'b1;    // Cannot overflow, only live arrays free
      end
      if (sizeWrite) sizes[lookupArray] <= newSize;
    end
  end

endmodule

// ==== hw/requestQueue.sv ====
//------------------------------
// Request FIFO between the host and the controller. Each pop
// frees one entry, which the top level returns as a credit.
//------------------------------
`timescale 1ns/1ps
`include "heap_config.svh"

module requestQueue import heapPkg::*; #(
  parameter int depth = `HEAP_QUEUE_DEPTH            // Entries, 2 or more
) (
  input  logic       clock,
  input  logic       resetN,
  input  logic       pushValid,                      // New request from host
  input  heapOp_t    pushOp,
  input  arrayNum_t  pushArray,
  input  elemIndex_t pushIndex,
  input  heapData_t  pushData,
  input  logic       queuePop,                       // Controller takes the head
  output logic       queueValid,                     // Head holds a request
  output heapOp_t    headOp,
  output arrayNum_t  headArray,
  output elemIndex_t headIndex,
  output heapData_t  headData
);

  localparam int ptrBits = $clog2(depth);
  localparam int cntBits = $clog2(depth + 1);

  typedef logic [ptrBits-1:0] queuePtr_t;
  typedef logic [cntBits-1:0] queueCnt_t;

  heapOp_t    opMem    [depth];                      // Payload storage
  arrayNum_t  arrayMem [depth];
  elemIndex_t indexMem [depth];
  heapData_t  dataMem  [depth];

  queuePtr_t  wrPtr, rdPtr;
  queueCnt_t  count;                                 // Occupancy

  // Wraps at depth, which need not be a power of two
  function automatic queuePtr_t nextPtr(input queuePtr_t ptr);
    if (ptr == queuePtr_t'(depth - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clock) begin
    if (pushValid) begin
      opMem[wrPtr]    <= pushOp;                     // Store the whole request
      arrayMem[wrPtr] <= pushArray;
      indexMem[wrPtr] <= pushIndex;
      dataMem[wrPtr]  <= pushData;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (pushValid) wrPtr <= nextPtr(wrPtr);
      if (queuePop)  rdPtr <= nextPtr(rdPtr);
      case ({pushValid, queuePop})
        2'b10:   count <= count + 1'b1;              // Fill only
        2'b01:   count <= count - 1'b1;              // Drain only
        default: count <= count;                     // Both or neither
      endcase
    end
  end

  assign queueValid = (count != '0);
  assign headOp     = opMem[rdPtr];                  // Oldest request
  assign headArray  = arrayMem[rdPtr];
  assign headIndex  = indexMem[rdPtr];
  assign headData   = dataMem[rdPtr];

endmodule

// ==== hw/heapPkg.sv ====
//------------------------------
// Shared types for the array heap: opcodes, error codes,
// controller states and the field types of a request
//------------------------------
`include "heap_config.svh"

package heapPkg;

  // Request opcodes
  typedef enum logic [3:0] {
    opWrite, opRead, opSize, opPush, opPop,          // Access and stack use
    opAlloc, opFree,                                 // Array lifetime
    opAdd, opAddAfter, opSub, opSubAfter,            // Arithmetic, new or old value
    opOr, opXor, opAnd, opNot                        // Bitwise updates
  } heapOp_t;

  // Response error codes
  typedef enum logic [2:0] {
    errNone, errUnallocated, errFreed, errOutOfBounds,
    errFull, errEmpty, errOutOfMemory
  } heapError_t;

  // Controller FSM
  typedef enum logic [1:0] {
    stIdle, stAccess, stUpdate, stRespond
  } ctrlState_t;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNum_t;   // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIndex_t;  // Element index
  typedef logic [`HEAP_INDEX_BITS:0]   arraySize_t;  // Size 0 to full, one bit wider
  typedef logic [`HEAP_DATA_BITS-1:0]  heapData_t;   // Element value

endpackage

// ==== hw/heap_config.svh ====
//------------------------------
// Size settings for the array heap, shared by the package,
// the RTL and the testbench. Include before the module header.
//------------------------------
`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

//------------------------------
// Primary sizes
//------------------------------
`define HEAP_ARRAY_BITS   3                           // Array number width, 8 arrays
`define HEAP_INDEX_BITS   2                           // Index width, 4 elements each
`define HEAP_DATA_BITS    16                          // Element width
`define HEAP_QUEUE_DEPTH  4                           // Queue entries, also host credits

//------------------------------
// Derived counts
//------------------------------
`define HEAP_ARRAYS       (1 << `HEAP_ARRAY_BITS)     // Arrays in the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)     // Elements per array

`endif
